// ==== sim/fpu_input.txt ====
// op a b tag result status, all hex; op 0 SGNJ 1 SGNJN 2 SGNJX 3 MIN 4 MAX
// 5 FEQ 6 FLT 7 FLE 8 CLASS; status bit 4 is NV
0 3f800000 c0000000 0 bf800000 00
1 bf800000 c0000000 1 3f800000 00
2 bf800000 c0000000 2 3f800000 00
3 3f800000 40000000 3 3f800000 00
4 3f800000 c0000000 4 3f800000 00
3 00000000 80000000 5 80000000 00
3 7fc00000 40400000 6 40400000 00
4 7fc00001 7f800001 7 7fc00000 10
3 7f800001 bf800000 8 bf800000 10
5 3f800000 3f800000 9 00000001 00
5 7fc00000 3f800000 a 00000000 00
5 7f800001 3f800000 b 00000000 10
6 bf800000 3f800000 c 00000001 00
7 7fc00000 3f800000 d 00000000 10
8 ff800000 00000000 e 00000001 00
8 7fc00000 00000000 f 00000200 00

// ==== files.f ====
+incdir+logic
logic/fpu_data_pkg.sv
logic/fpu_op_pkg.sv
logic/fpu_sign_minmax.sv
logic/fpu_cmp_class.sv
logic/fpu_result_arbiter.sv
logic/fpu_top.sv
sim/fpu_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f files.f \
  --top-module fpu_top_tb -o fpu_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fpu_top_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== sim/fpu_top_tb.sv ====
// -----------------------------------------------
// FPU testbench
// Replays operations from the input file under
// random output back-pressure and checks results
// -----------------------------------------------

`include "fpu_defines.svh"

`default_nettype none

module fpu_top_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_tags   = 1 << `FPU_TAG_W;
  localparam int wait_max = 200;

  logic                   clk_i = 1'b0;
  logic                   reset_i, in_valid_i, out_ready_i;
  logic                   in_ready_o, out_valid_o, busy_o;
  fpu_data_pkg::fp32_t    operand_a_i, operand_b_i, result_o;
  fpu_op_pkg::operation_e op_i;
  fpu_data_pkg::tag_t     tag_i, tag_o;
  fpu_data_pkg::status_t  status_o;

  // Operations in file order
  fpu_op_pkg::operation_e ops[n_tags];
  fpu_data_pkg::fp32_t    a_in[n_tags];
  fpu_data_pkg::fp32_t    b_in[n_tags];
  fpu_data_pkg::tag_t     tag_in[n_tags];
  int                     n_ops;

  // Expected values by tag
  fpu_data_pkg::fp32_t    exp_result[n_tags];
  fpu_data_pkg::status_t  exp_status[n_tags];
  logic                   tag_used[n_tags];
  logic                   tag_seen[n_tags];
  // High for compare and classify operations
  logic                   tag_cc[n_tags];
  fpu_data_pkg::tag_t     sm_order[$];
  fpu_data_pkg::tag_t     cc_order[$];
  logic [15:0]            lfsr_q;

  always #50 clk_i = ~clk_i;

  fpu_top UUT (
    .clk_i, .reset_i, .operand_a_i, .operand_b_i, .op_i, .tag_i, .in_valid_i,
    .in_ready_o, .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i, .busy_o
  );

  // Taps 16, 15, 13, 4
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
  endfunction

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // -----------------------------------------------
  // Compare tasks
  // -----------------------------------------------
  task automatic check_result(input string name, input fpu_data_pkg::fp32_t exp,
                              input fpu_data_pkg::fp32_t act);
    if (act !== exp) begin
      $display("Fail %s: expected result %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(input string name, input fpu_data_pkg::status_t exp,
                              input fpu_data_pkg::status_t act);
    if (act !== exp) begin
      $display("Fail %s: expected status %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_tag(input string name, input fpu_data_pkg::tag_t exp,
                           input fpu_data_pkg::tag_t act);
    if (!tag_used[act]) begin
      $display("Tag %0d came back but no operation in the input file uses it", act);
      stop_run();
    end else if (tag_seen[act]) begin
      $display("Tag %0d came back a second time", act);
      stop_run();
    end else if (act !== exp) begin
      $display("Fail %s: expected tag %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // -----------------------------------------------
  // Stimulus file and drivers
  // -----------------------------------------------
  task automatic read_input();
    int                  fd;
    int                  code;
    string               line;
    logic [3:0]          f_op;
    logic [4:0]          f_st;
    fpu_data_pkg::fp32_t f_a, f_b, f_res;
    fpu_data_pkg::tag_t  f_tag;
    fd = $fopen("sim/fpu_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file sim/fpu_input.txt");
      stop_run();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // Comment and empty lines do not scan into six fields
      if (code != 0 &&
          $sscanf(line, "%h %h %h %h %h %h", f_op, f_a, f_b, f_tag, f_res, f_st) == 6) begin
        if (n_ops == n_tags || tag_used[f_tag]) begin
          $display("Input file holds a repeated tag or too many operations");
          stop_run();
        end
        ops[n_ops]        = fpu_op_pkg::operation_e'(f_op);
        a_in[n_ops]       = f_a;
        b_in[n_ops]       = f_b;
        tag_in[n_ops]     = f_tag;
        exp_result[f_tag] = f_res;
        exp_status[f_tag] = fpu_data_pkg::status_t'(f_st);
        tag_used[f_tag]   = 1'b1;
        tag_cc[f_tag]     = (f_op >= 4'd5);
        n_ops++;
      end
    end
    $fclose(fd);
  endtask

  task automatic send_op(input int idx);
    int waited;
    operand_a_i <= a_in[idx];
    operand_b_i <= b_in[idx];
    op_i        <= ops[idx];
    tag_i       <= tag_in[idx];
    in_valid_i  <= 1'b1;
    if (tag_cc[tag_in[idx]])
      cc_order.push_back(tag_in[idx]);
    else
      sm_order.push_back(tag_in[idx]);
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > wait_max) begin
        $display("Timeout: input handshake for tag %0d never completed", tag_in[idx]);
        stop_run();
      end
    end while (!in_ready_o);
  endtask

  task automatic collect_results();
    int                    received;
    int                    idle;
    logic                  stalled;
    string                 name;
    fpu_data_pkg::fp32_t   held_result;
    fpu_data_pkg::status_t held_status;
    fpu_data_pkg::tag_t    held_tag, exp_tag;
    received = 0;
    idle     = 0;
    stalled  = 1'b0;
    while (received < n_ops) begin
      @(posedge clk_i);
      idle++;
      if (idle > wait_max) begin
        $display("Timeout: no result handshake for %0d cycles", wait_max);
        stop_run();
      end
      // A stalled result has to stay put until it is taken
      if (stalled) begin
        check_flag("out_valid_o held under back-pressure", 1'b1, out_valid_o);
        check_result("result held under back-pressure", held_result, result_o);
        check_status("status held under back-pressure", held_status, status_o);
        check_tag("tag held under back-pressure", held_tag, tag_o);
      end
      stalled = out_valid_o & ~out_ready_i;
      held_result = result_o;
      held_status = status_o;
      held_tag    = tag_o;
      if (out_valid_o & out_ready_i) begin
        name = $sformatf("tag %0d", tag_o);
        if (tag_cc[tag_o] && cc_order.size() > 0)
          exp_tag = cc_order.pop_front();
        else if (!tag_cc[tag_o] && sm_order.size() > 0)
          exp_tag = sm_order.pop_front();
        else begin
          $display("Tag %0d came back while no operation of its group was outstanding",
                   tag_o);
          stop_run();
        end
        check_tag(name, exp_tag, tag_o);
        check_result(name, exp_result[tag_o], result_o);
        check_status(name, exp_status[tag_o], status_o);
        tag_seen[tag_o] = 1'b1;
        received++;
        idle = 0;
      end
      lfsr_q = lfsr_step(lfsr_q);
      out_ready_i <= lfsr_q[0];
    end
  endtask

  initial begin
    int waited;
    reset_i     <= 1'b1;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b0;
    operand_a_i <= '0;
    operand_b_i <= '0;
    op_i        <= fpu_op_pkg::SGNJ;
    tag_i       <= '0;
    lfsr_q = 16'd12;
    n_ops  = 0;
    for (int i = 0; i < n_tags; i++) begin
      tag_used[i] = 1'b0;
      tag_seen[i] = 1'b0;
      tag_cc[i]   = 1'b0;
    end
    read_input();
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_flag("out_valid_o after reset", 1'b0, out_valid_o);
    check_flag("busy_o after reset", 1'b0, busy_o);
    check_flag("in_ready_o after reset", 1'b1, in_ready_o);
    fork
      begin
        for (int i = 0; i < n_ops; i++)
          send_op(i);
        in_valid_i <= 1'b0;
      end
      collect_results();
    join
    waited = 0;
    while (busy_o) begin
      @(posedge clk_i);
      waited++;
      if (waited > wait_max) begin
        $display("Timeout: busy_o stayed high after the last result");
        stop_run();
      end
    end
    check_flag("in_ready_o when idle", 1'b1, in_ready_o);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/fpu_top.sv ====
// -----------------------------------------------
// FPU top level
// Dispatches requests to the two operation groups
// and merges their results through the arbiter
// -----------------------------------------------

`include "fpu_defines.svh"

`default_nettype none

module fpu_top #(
  parameter int unsigned tag_width = `FPU_TAG_W
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  fpu_data_pkg::fp32_t    operand_a_i,
  input  fpu_data_pkg::fp32_t    operand_b_i,
  input  fpu_op_pkg::operation_e op_i,
  input  fpu_data_pkg::tag_t     tag_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output fpu_data_pkg::fp32_t    result_o,
  output fpu_data_pkg::status_t  status_o,
  output fpu_data_pkg::tag_t     tag_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);

  fpu_op_pkg::fp_request_t  req;
  fpu_op_pkg::opgroup_e     req_grp;
  logic                     sm_req_valid, sm_req_ready, sm_res_valid, sm_res_ready, sm_busy;
  logic                     cc_req_valid, cc_req_ready, cc_res_valid, cc_res_ready, cc_busy;
  fpu_data_pkg::fp_result_t sm_res, cc_res, out_res;

  assign req.a   = operand_a_i;
  assign req.b   = operand_b_i;
  assign req.op  = op_i;
  assign req.tag = tag_i[tag_width-1:0];

  // Steer the request to its group
  assign req_grp      = fpu_op_pkg::get_opgroup(op_i);
  assign sm_req_valid = in_valid_i & (req_grp == fpu_op_pkg::SIGN_MINMAX);
  assign cc_req_valid = in_valid_i & (req_grp == fpu_op_pkg::CMP_CLASS);
  assign in_ready_o   = (req_grp == fpu_op_pkg::CMP_CLASS) ? cc_req_ready : sm_req_ready;
  assign busy_o       = sm_busy | cc_busy;

  fpu_sign_minmax u_sign_minmax (
    .clk_i, .reset_i, .req_i(req), .req_valid_i(sm_req_valid), .req_ready_o(sm_req_ready),
    .res_o(sm_res), .res_valid_o(sm_res_valid), .res_ready_i(sm_res_ready), .busy_o(sm_busy)
  );

  fpu_cmp_class u_cmp_class (
    .clk_i, .reset_i, .req_i(req), .req_valid_i(cc_req_valid), .req_ready_o(cc_req_ready),
    .res_o(cc_res), .res_valid_o(cc_res_valid), .res_ready_i(cc_res_ready), .busy_o(cc_busy)
  );

  fpu_result_arbiter u_arbiter (
    .clk_i, .reset_i,
    .sm_res_i(sm_res), .sm_valid_i(sm_res_valid), .sm_ready_o(sm_res_ready),
    .cc_res_i(cc_res), .cc_valid_i(cc_res_valid), .cc_ready_o(cc_res_ready),
    .out_res_o(out_res), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i)
  );

  assign result_o = out_res.result;
  assign status_o = out_res.status;
  assign tag_o    = out_res.tag[tag_width-1:0];

endmodule

`default_nettype wire

// ==== logic/fpu_result_arbiter.sv ====
// -----------------------------------------------
// Result arbiter
// Round-robin merge of the two group outputs that
// holds its grant while the output is stalled
// -----------------------------------------------

`default_nettype none

module fpu_result_arbiter (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  fpu_data_pkg::fp_result_t sm_res_i,
  input  logic                     sm_valid_i,
  output logic                     sm_ready_o,
  input  fpu_data_pkg::fp_result_t cc_res_i,
  input  logic                     cc_valid_i,
  output logic                     cc_ready_o,
  output fpu_data_pkg::fp_result_t out_res_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  // Grant encoding: 0 picks sign/minmax, 1 picks compare/classify
  logic sel;
  logic last_q;
  logic lock_q, lock_sel_q;

  always_comb begin
    if (lock_q)
      sel = lock_sel_q;
    else if (sm_valid_i & cc_valid_i)
      sel = ~last_q;
    else
      sel = cc_valid_i;
  end

  assign out_valid_o = sel ? cc_valid_i : sm_valid_i;
  assign out_res_o   = sel ? cc_res_i : sm_res_i;

  // Only the granted group sees ready
  assign sm_ready_o  = out_ready_i & ~sel;
  assign cc_ready_o  = out_ready_i & sel;

  // ---------------------------------------------
  // Pointer and lock
  // ---------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else if (out_valid_o & out_ready_i) begin
      last_q <= sel;
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      // Offered but stalled, keep this group until taken
      lock_q     <= 1'b1;
      lock_sel_q <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fpu_cmp_class.sv ====
// -----------------------------------------------
// Compare and classify group
// Stage 1 decodes both operands, stage 2 forms the
// FEQ/FLT/FLE result or the RISC-V class mask
// -----------------------------------------------

`include "fpu_defines.svh"

`default_nettype none

module fpu_cmp_class (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  fpu_op_pkg::fp_request_t  req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output fpu_data_pkg::fp_result_t res_o,
  output logic                     res_valid_o,
  input  logic                     res_ready_i,
  output logic                     busy_o
);

  typedef struct packed {
    logic sign;
    logic zero;
    logic subnormal;
    logic normal;
    logic inf;
    logic qnan;
    logic snan;
  } fp_info_t;

  typedef struct packed {
    fp_info_t                ia;
    fp_info_t                ib;
    fpu_data_pkg::fp32_t     a;
    fpu_data_pkg::fp32_t     b;
    fpu_op_pkg::operation_e  op;
    fpu_data_pkg::tag_t      tag;
  } stage1_t;

  stage1_t                   s1_q;
  logic                      s1_valid_q, s2_valid_q;
  logic                      s1_ready, s2_ready;
  logic                      any_nan, any_snan, both_zero, eq, lt;
  logic [`FPU_CLASS_W-1:0]   class_mask;
  fpu_data_pkg::fp_result_t  res_d, res_q;

  function automatic fp_info_t decode(fpu_data_pkg::fp32_t x);
    logic     exp_ones, exp_zero, man_zero;
    fp_info_t info;
    exp_ones       = &x[`FPU_WIDTH-2 -: `FPU_EXP_W];
    exp_zero       = ~|x[`FPU_WIDTH-2 -: `FPU_EXP_W];
    man_zero       = ~|x[`FPU_MAN_W-1:0];
    info.sign      = x[`FPU_WIDTH-1];
    info.zero      = exp_zero & man_zero;
    info.subnormal = exp_zero & ~man_zero;
    info.normal    = ~exp_zero & ~exp_ones;
    info.inf       = exp_ones & man_zero;
    // Top mantissa bit separates quiet from signaling
    info.qnan      = exp_ones & ~man_zero & x[`FPU_MAN_W-1];
    info.snan      = exp_ones & ~man_zero & ~x[`FPU_MAN_W-1];
    return info;
  endfunction

  // A stage advances when the next one is empty or emptying
  assign s2_ready    = ~s2_valid_q | res_ready_i;
  assign s1_ready    = ~s1_valid_q | s2_ready;
  assign req_ready_o = s1_ready;

  // ---------------------------------------------
  // Stage 1 decode
  // ---------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i)
      s1_valid_q <= 1'b0;
    else if (s1_ready)
      s1_valid_q <= req_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i & s1_ready) begin
      s1_q.ia  <= decode(req_i.a);
      s1_q.ib  <= decode(req_i.b);
      s1_q.a   <= req_i.a;
      s1_q.b   <= req_i.b;
      s1_q.op  <= req_i.op;
      s1_q.tag <= req_i.tag;
    end
  end

  // ---------------------------------------------
  // Stage 2 compare and classify
  // ---------------------------------------------
  always_comb begin
    any_nan   = s1_q.ia.qnan | s1_q.ia.snan | s1_q.ib.qnan | s1_q.ib.snan;
    any_snan  = s1_q.ia.snan | s1_q.ib.snan;
    both_zero = s1_q.ia.zero & s1_q.ib.zero;
    eq        = ~any_nan & (both_zero | (s1_q.a == s1_q.b));
    if (any_nan | both_zero)
      lt = 1'b0;
    else if (s1_q.ia.sign != s1_q.ib.sign)
      lt = s1_q.ia.sign;
    else if (s1_q.ia.sign)
      lt = s1_q.a[`FPU_WIDTH-2:0] > s1_q.b[`FPU_WIDTH-2:0];
    else
      lt = s1_q.a[`FPU_WIDTH-2:0] < s1_q.b[`FPU_WIDTH-2:0];
  end

  // RISC-V order, bit 0 is -inf and bit 9 is quiet NaN
  assign class_mask = {s1_q.ia.qnan, s1_q.ia.snan,
                       ~s1_q.ia.sign & s1_q.ia.inf, ~s1_q.ia.sign & s1_q.ia.normal,
                       ~s1_q.ia.sign & s1_q.ia.subnormal, ~s1_q.ia.sign & s1_q.ia.zero,
                       s1_q.ia.sign & s1_q.ia.zero, s1_q.ia.sign & s1_q.ia.subnormal,
                       s1_q.ia.sign & s1_q.ia.normal, s1_q.ia.sign & s1_q.ia.inf};

  always_comb begin
    res_d     = '0;
    res_d.tag = s1_q.tag;
    case (s1_q.op)
      fpu_op_pkg::FEQ: begin
        res_d.result    = {{(`FPU_WIDTH-1){1'b0}}, eq};
        res_d.status.nv = any_snan;
      end
      fpu_op_pkg::FLT: begin
        res_d.result    = {{(`FPU_WIDTH-1){1'b0}}, lt};
        res_d.status.nv = any_nan;
      end
      fpu_op_pkg::FLE: begin
        res_d.result    = {{(`FPU_WIDTH-1){1'b0}}, lt | eq};
        res_d.status.nv = any_nan;
      end
      fpu_op_pkg::CLASS: res_d.result = {{(`FPU_WIDTH-`FPU_CLASS_W){1'b0}}, class_mask};
      default:           res_d.result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      s2_valid_q <= 1'b0;
    else if (s2_ready)
      s2_valid_q <= s1_valid_q;
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q & s2_ready)
      res_q <= res_d;
  end

  assign res_o       = res_q;
  assign res_valid_o = s2_valid_q;
  assign busy_o      = s1_valid_q | s2_valid_q;

endmodule

`default_nettype wire

// ==== logic/fpu_sign_minmax.sv ====
// -----------------------------------------------
// Sign injection and min/max group
// Single-cycle datapath into a one-entry output
// register, minimumNumber semantics for MIN/MAX
// -----------------------------------------------

`include "fpu_defines.svh"

`default_nettype none

module fpu_sign_minmax (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  fpu_op_pkg::fp_request_t  req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output fpu_data_pkg::fp_result_t res_o,
  output logic                     res_valid_o,
  input  logic                     res_ready_i,
  output logic                     busy_o
);

  localparam fpu_data_pkg::fp32_t canonical_nan = 32'h7FC0_0000;

  fpu_data_pkg::fp32_t      a, b;
  logic                     a_nan, b_nan, a_snan, b_snan;
  logic                     a_lt_b;
  fpu_data_pkg::fp_result_t res_d, res_q;
  logic                     full_q;

  assign a = req_i.a;
  assign b = req_i.b;

  // NaN when exponent is all ones and mantissa is nonzero
  assign a_nan  = (&a[`FPU_WIDTH-2 -: `FPU_EXP_W]) & (|a[`FPU_MAN_W-1:0]);
  assign b_nan  = (&b[`FPU_WIDTH-2 -: `FPU_EXP_W]) & (|b[`FPU_MAN_W-1:0]);
  assign a_snan = a_nan & ~a[`FPU_MAN_W-1];
  assign b_snan = b_nan & ~b[`FPU_MAN_W-1];

  // Ordering of non-NaN operands, -0 sorts below +0
  always_comb begin
    if (a[`FPU_WIDTH-1] != b[`FPU_WIDTH-1])
      a_lt_b = a[`FPU_WIDTH-1];
    else if (a[`FPU_WIDTH-1])
      a_lt_b = a[`FPU_WIDTH-2:0] > b[`FPU_WIDTH-2:0];
    else
      a_lt_b = a[`FPU_WIDTH-2:0] < b[`FPU_WIDTH-2:0];
  end

  always_comb begin
    res_d     = '0;
    res_d.tag = req_i.tag;
    case (req_i.op)
      fpu_op_pkg::SGNJ:  res_d.result = {b[`FPU_WIDTH-1], a[`FPU_WIDTH-2:0]};
      fpu_op_pkg::SGNJN: res_d.result = {~b[`FPU_WIDTH-1], a[`FPU_WIDTH-2:0]};
      fpu_op_pkg::SGNJX: res_d.result = {a[`FPU_WIDTH-1] ^ b[`FPU_WIDTH-1], a[`FPU_WIDTH-2:0]};
      fpu_op_pkg::MIN, fpu_op_pkg::MAX: begin
        res_d.status.nv = a_snan | b_snan;
        if (a_nan & b_nan)
          res_d.result = canonical_nan;
        else if (a_nan)
          res_d.result = b;
        else if (b_nan)
          res_d.result = a;
        else if ((req_i.op == fpu_op_pkg::MIN) == a_lt_b)
          res_d.result = a;
        else
          res_d.result = b;
      end
      default: res_d.result = '0;
    endcase
  end

  // ---------------------------------------------
  // Output register
  // ---------------------------------------------
  assign req_ready_o = ~full_q | res_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      full_q <= 1'b0;
    else if (req_valid_i & req_ready_o)
      full_q <= 1'b1;
    else if (res_ready_i)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i & req_ready_o)
      res_q <= res_d;
  end

  assign res_o       = res_q;
  assign res_valid_o = full_q;
  assign busy_o      = full_q;

endmodule

`default_nettype wire

// ==== logic/fpu_op_pkg.sv ====
// -----------------------------------------------
// FPU operation types
// Operation codes, operation groups, the request
// record and the mapping of operation to group
// -----------------------------------------------

`default_nettype none

package fpu_op_pkg;

  typedef enum logic [3:0] {
    SGNJ  = 4'd0,
    SGNJN = 4'd1,
    SGNJX = 4'd2,
    MIN   = 4'd3,
    MAX   = 4'd4,
    FEQ   = 4'd5,
    FLT   = 4'd6,
    FLE   = 4'd7,
    CLASS = 4'd8
  } operation_e;

  typedef enum logic {
    SIGN_MINMAX = 1'b0,
    CMP_CLASS   = 1'b1
  } opgroup_e;

  typedef struct packed {
    fpu_data_pkg::fp32_t a;
    fpu_data_pkg::fp32_t b;
    operation_e          op;
    fpu_data_pkg::tag_t  tag;
  } fp_request_t;

  // Group that executes a given operation
  function automatic opgroup_e get_opgroup(operation_e op);
    case (op)
      SGNJ, SGNJN, SGNJX, MIN, MAX: return SIGN_MINMAX;
      default:                      return CMP_CLASS;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== logic/fpu_data_pkg.sv ====
// -----------------------------------------------
// FPU data types
// Floating-point words, status flags, tags and the
// result record passed from groups to the output
// -----------------------------------------------

`include "fpu_defines.svh"

`default_nettype none

package fpu_data_pkg;

  // One single-precision word
  typedef logic [`FPU_WIDTH-1:0] fp32_t;

  typedef logic [`FPU_TAG_W-1:0] tag_t;

  // IEEE exception flags, NV in the top bit
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Result record of one operation
  typedef struct packed {
    fp32_t   result;
    status_t status;
    tag_t    tag;
  } fp_result_t;

endpackage

`default_nettype wire

// ==== logic/fpu_defines.svh ====
// -----------------------------------------------
// FPU width definitions
// Field widths of single-precision words, tag and
// class-mask widths shared by the packages and RTL
// -----------------------------------------------

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Single-precision word and its fields
`define FPU_WIDTH   32
`define FPU_EXP_W   8
`define FPU_MAN_W   23

`define FPU_TAG_W   4
`define FPU_CLASS_W 10

`endif
